// ==== flist.f ====
hw/bridge_cmd_pkg.sv
hw/mc_net_pkg.sv
hw/eva_decode.sv
hw/packet_issue.sv
hw/return_table.sv
hw/mc_bridge_top.sv
test/tb_mc_bridge.sv

// ==== hw/bridge_cmd_pkg.sv ====
package bridge_cmd_pkg;

  //////////////////////////////////////////////////////////////////////
  // command port
  //////////////////////////////////////////////////////////////////////

  // byte address and data word of a processor command
  localparam int cmd_addr_width = 32;
  localparam int word_width     = 32;

  // opaque tag, returned untouched with the response
  localparam int tag_width      = 4;

  // one mask bit per byte lane
  localparam int mask_width     = word_width / 8;
  localparam int lane_width     = $clog2(mask_width);

  // access size codes
  typedef logic [1:0] size_t;

  localparam size_t size_1 = 2'd0;
  localparam size_t size_2 = 2'd1;
  localparam size_t size_4 = 2'd2;

  //////////////////////////////////////////////////////////////////////
  // transaction ids
  //////////////////////////////////////////////////////////////////////

  localparam int max_outstanding = 4;
  localparam int trans_id_width  = $clog2(max_outstanding);

  typedef logic [trans_id_width-1:0] trans_id_t;

  //////////////////////////////////////////////////////////////////////
  // address layout
  //////////////////////////////////////////////////////////////////////

  // set for DRAM, clear for a tile in the array
  localparam int remote_bit     = 31;

  // local tile fields
  localparam int local_y_lsb    = 24;
  localparam int local_x_lsb    = 18;
  localparam int local_word_msb = 17;

endpackage

// ==== hw/eva_decode.sv ====
module eva_decode (
  input  logic [bridge_cmd_pkg::cmd_addr_width-1:0] addr_i,
  input  bridge_cmd_pkg::size_t                     size_i,
  output mc_net_pkg::cord_t                         dst_x_o,
  output mc_net_pkg::cord_t                         dst_y_o,
  output mc_net_pkg::mc_addr_t                      word_addr_o,
  output logic [bridge_cmd_pkg::mask_width-1:0]     mask_o,
  output logic [bridge_cmd_pkg::lane_width-1:0]     lane_o
);

  import bridge_cmd_pkg::*;
  import mc_net_pkg::*;

  // word index of a DRAM address, bits 30..2
  logic [remote_bit-lane_width-1:0] word_idx;
  logic [bank_width-1:0]            bank;
  logic [lane_width-1:0]            lane;

  assign lane     = addr_i[lane_width-1:0];
  assign word_idx = addr_i[remote_bit-1:lane_width];

  // low bits of the word index pick the bank
  assign bank     = word_idx[bank_width-1:0];

  assign lane_o   = lane;

  //////////////////////////////////////////////////////////////////////
  // destination
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    if (!addr_i[remote_bit])
    begin
      dst_y_o     = addr_i[local_y_lsb+:cord_width];
      dst_x_o     = addr_i[local_x_lsb+:cord_width];
      word_addr_o = mc_addr_t'(addr_i[local_word_msb:lane_width]);
    end
    else
    begin
      // bank msb selects the row below the array, else row 0 on top
      dst_x_o     = cord_t'(bank[x_sub_width-1:0]);
      dst_y_o     = bank[bank_width-1] ? cord_t'(num_tiles_y + 1) : '0;
      // remaining index bits address the word inside the bank
      word_addr_o = mc_addr_t'(word_idx >> bank_width);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // byte mask
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    case (size_i)
      size_1:
        mask_o = 4'h1 << lane;
      size_2:
        mask_o = 4'h3 << lane;
      size_4:
        mask_o = 4'hf << lane;
      default:
        // unused code, no bytes enabled
        mask_o = '0;
    endcase
  end

endmodule

// ==== hw/mc_bridge_top.sv ====
module mc_bridge_top (
  input  logic                                      clk_i,
  input  logic                                      arst_n_i,

  input  mc_net_pkg::cord_t                         my_x_i,
  input  mc_net_pkg::cord_t                         my_y_i,

  // processor commands
  input  logic                                      cmd_valid_i,
  output logic                                      cmd_ready_o,
  input  logic [bridge_cmd_pkg::cmd_addr_width-1:0] cmd_addr_i,
  input  logic                                      cmd_we_i,
  input  bridge_cmd_pkg::size_t                     cmd_size_i,
  input  logic [bridge_cmd_pkg::word_width-1:0]     cmd_data_i,
  input  logic [bridge_cmd_pkg::tag_width-1:0]      cmd_tag_i,

  // requests into the mesh
  output logic                                      pkt_v_o,
  input  logic                                      pkt_ready_i,
  output mc_net_pkg::op_e                           pkt_op_o,
  output mc_net_pkg::mc_addr_t                      pkt_addr_o,
  output logic [bridge_cmd_pkg::mask_width-1:0]     pkt_mask_o,
  output mc_net_pkg::payload_u                      pkt_payload_o,
  output bridge_cmd_pkg::trans_id_t                 pkt_reg_id_o,
  output mc_net_pkg::cord_t                         pkt_x_o,
  output mc_net_pkg::cord_t                         pkt_y_o,
  output mc_net_pkg::cord_t                         pkt_src_x_o,
  output mc_net_pkg::cord_t                         pkt_src_y_o,

  // returns from the mesh, always accepted
  input  logic                                      ret_v_i,
  input  bridge_cmd_pkg::trans_id_t                 ret_reg_id_i,
  input  logic [bridge_cmd_pkg::word_width-1:0]     ret_data_i,

  // responses to the processor
  output logic                                      resp_v_o,
  input  logic                                      resp_ready_i,
  output logic [bridge_cmd_pkg::tag_width-1:0]      resp_tag_o,
  output logic                                      resp_we_o,
  output logic [bridge_cmd_pkg::word_width-1:0]     resp_data_o
);

  logic                                  alloc_v;
  logic                                  alloc_ready;
  bridge_cmd_pkg::trans_id_t             alloc_id;
  logic [bridge_cmd_pkg::lane_width-1:0] cmd_lane;

  packet_issue u_issue (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .cmd_valid_i   (cmd_valid_i),
    .cmd_ready_o   (cmd_ready_o),
    .cmd_addr_i    (cmd_addr_i),
    .cmd_we_i      (cmd_we_i),
    .cmd_size_i    (cmd_size_i),
    .cmd_data_i    (cmd_data_i),
    .lane_o        (cmd_lane),
    .my_x_i        (my_x_i),
    .my_y_i        (my_y_i),
    .pkt_v_o       (pkt_v_o),
    .pkt_ready_i   (pkt_ready_i),
    .pkt_op_o      (pkt_op_o),
    .pkt_addr_o    (pkt_addr_o),
    .pkt_mask_o    (pkt_mask_o),
    .pkt_payload_o (pkt_payload_o),
    .pkt_reg_id_o  (pkt_reg_id_o),
    .pkt_x_o       (pkt_x_o),
    .pkt_y_o       (pkt_y_o),
    .pkt_src_x_o   (pkt_src_x_o),
    .pkt_src_y_o   (pkt_src_y_o),
    .alloc_id_i    (alloc_id),
    .alloc_ready_i (alloc_ready),
    .alloc_v_o     (alloc_v)
  );

  return_table u_table (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .alloc_v_i     (alloc_v),
    .alloc_id_o    (alloc_id),
    .alloc_ready_o (alloc_ready),
    .cmd_tag_i     (cmd_tag_i),
    .cmd_we_i      (cmd_we_i),
    .cmd_size_i    (cmd_size_i),
    .lane_i        (cmd_lane),
    .ret_v_i       (ret_v_i),
    .ret_reg_id_i  (ret_reg_id_i),
    .ret_data_i    (ret_data_i),
    .resp_v_o      (resp_v_o),
    .resp_ready_i  (resp_ready_i),
    .resp_tag_o    (resp_tag_o),
    .resp_we_o     (resp_we_o),
    .resp_data_o   (resp_data_o)
  );

endmodule

// ==== hw/mc_net_pkg.sv ====
package mc_net_pkg;

  //////////////////////////////////////////////////////////////////////
  // packet fields
  //////////////////////////////////////////////////////////////////////

  localparam int cord_width     = 6;
  localparam int pkt_addr_width = 28;

  typedef logic [cord_width-1:0]     cord_t;
  typedef logic [pkt_addr_width-1:0] mc_addr_t;

  // network opcode
  typedef enum logic
  {
    e_load  = 1'b0,
    e_store = 1'b1
  } op_e;

  // what a load asks the target to do with the word
  typedef struct packed
  {
    logic                                  is_byte;
    logic                                  is_half;
    logic [bridge_cmd_pkg::lane_width-1:0] part_sel;
  } load_info_t;

  // the same payload word, read as store data or as load info
  typedef union packed
  {
    logic [bridge_cmd_pkg::word_width-1:0] store_data;
    struct packed
    {
      logic [bridge_cmd_pkg::word_width-$bits(load_info_t)-1:0] pad;
      load_info_t                                                info;
    } load;
  } payload_u;

  //////////////////////////////////////////////////////////////////////
  // mesh geometry
  //////////////////////////////////////////////////////////////////////

  localparam int num_tiles_x = 4;
  localparam int num_tiles_y = 4;

  // one DRAM bank per column above and per column below the array
  localparam int num_banks   = 2 * num_tiles_x;

  localparam int bank_width  = $clog2(num_banks);
  localparam int x_sub_width = $clog2(num_tiles_x);

endpackage

// ==== hw/packet_issue.sv ====
module packet_issue (
  input  logic                                      clk_i,
  input  logic                                      arst_n_i,

  input  logic                                      cmd_valid_i,
  output logic                                      cmd_ready_o,
  input  logic [bridge_cmd_pkg::cmd_addr_width-1:0] cmd_addr_i,
  input  logic                                      cmd_we_i,
  input  bridge_cmd_pkg::size_t                     cmd_size_i,
  input  logic [bridge_cmd_pkg::word_width-1:0]     cmd_data_i,
  output logic [bridge_cmd_pkg::lane_width-1:0]     lane_o,

  input  mc_net_pkg::cord_t                         my_x_i,
  input  mc_net_pkg::cord_t                         my_y_i,

  output logic                                      pkt_v_o,
  input  logic                                      pkt_ready_i,
  output mc_net_pkg::op_e                           pkt_op_o,
  output mc_net_pkg::mc_addr_t                      pkt_addr_o,
  output logic [bridge_cmd_pkg::mask_width-1:0]     pkt_mask_o,
  output mc_net_pkg::payload_u                      pkt_payload_o,
  output bridge_cmd_pkg::trans_id_t                 pkt_reg_id_o,
  output mc_net_pkg::cord_t                         pkt_x_o,
  output mc_net_pkg::cord_t                         pkt_y_o,
  output mc_net_pkg::cord_t                         pkt_src_x_o,
  output mc_net_pkg::cord_t                         pkt_src_y_o,

  input  bridge_cmd_pkg::trans_id_t                 alloc_id_i,
  input  logic                                      alloc_ready_i,
  output logic                                      alloc_v_o
);

  import bridge_cmd_pkg::*;
  import mc_net_pkg::*;

  cord_t                 dst_x;
  cord_t                 dst_y;
  mc_addr_t              word_addr;
  logic [mask_width-1:0] mask;
  logic [lane_width-1:0] lane;
  payload_u              payload_d;
  logic                  pkt_v_r;
  logic                  pkt_free;
  logic                  cmd_xfer;

  eva_decode u_decode (
    .addr_i      (cmd_addr_i),
    .size_i      (cmd_size_i),
    .dst_x_o     (dst_x),
    .dst_y_o     (dst_y),
    .word_addr_o (word_addr),
    .mask_o      (mask),
    .lane_o      (lane)
  );

  assign lane_o = lane;

  // packet register can take a new one if empty or emptying now
  assign pkt_free    = ~pkt_v_r | pkt_ready_i;
  assign cmd_ready_o = alloc_ready_i & pkt_free;
  assign cmd_xfer    = cmd_valid_i & cmd_ready_o;
  assign alloc_v_o   = cmd_xfer;

  // stores shift data onto their lanes, loads carry size and lane
  always_comb
  begin
    payload_d = '0;
    if (cmd_we_i)
      payload_d.store_data = cmd_data_i << {lane, 3'b000};
    else
    begin
      payload_d.load.info.is_byte  = (cmd_size_i == size_1);
      payload_d.load.info.is_half  = (cmd_size_i == size_2);
      payload_d.load.info.part_sel = lane;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // outgoing packet register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      pkt_v_r <= 1'b0;
    else if (pkt_free)
      pkt_v_r <= cmd_xfer;
  end

  always_ff @(posedge clk_i)
  begin
    if (cmd_xfer)
    begin
      pkt_op_o      <= cmd_we_i ? e_store : e_load;
      pkt_addr_o    <= word_addr;
      pkt_mask_o    <= mask;
      pkt_payload_o <= payload_d;
      pkt_reg_id_o  <= alloc_id_i;
      pkt_x_o       <= dst_x;
      pkt_y_o       <= dst_y;
      pkt_src_x_o   <= my_x_i;
      pkt_src_y_o   <= my_y_i;
    end
  end

  assign pkt_v_o = pkt_v_r;

endmodule

// ==== hw/return_table.sv ====
module return_table (
  input  logic                                  clk_i,
  input  logic                                  arst_n_i,

  input  logic                                  alloc_v_i,
  output bridge_cmd_pkg::trans_id_t             alloc_id_o,
  output logic                                  alloc_ready_o,

  input  logic [bridge_cmd_pkg::tag_width-1:0]  cmd_tag_i,
  input  logic                                  cmd_we_i,
  input  bridge_cmd_pkg::size_t                 cmd_size_i,
  input  logic [bridge_cmd_pkg::lane_width-1:0] lane_i,

  input  logic                                  ret_v_i,
  input  bridge_cmd_pkg::trans_id_t             ret_reg_id_i,
  input  logic [bridge_cmd_pkg::word_width-1:0] ret_data_i,

  output logic                                  resp_v_o,
  input  logic                                  resp_ready_i,
  output logic [bridge_cmd_pkg::tag_width-1:0]  resp_tag_o,
  output logic                                  resp_we_o,
  output logic [bridge_cmd_pkg::word_width-1:0] resp_data_o
);

  import bridge_cmd_pkg::*;

  // entry state, indexed by transaction id
  logic [max_outstanding-1:0] busy_r;
  logic [max_outstanding-1:0] filled_r;
  trans_id_t                  head_r;
  trans_id_t                  tail_r;

  // per-entry command context and returned word
  logic [tag_width-1:0]  tag_r  [max_outstanding];
  logic                  we_r   [max_outstanding];
  size_t                 size_r [max_outstanding];
  logic [lane_width-1:0] lane_r [max_outstanding];
  logic [word_width-1:0] data_r [max_outstanding];

  logic                  drain;
  logic [word_width-1:0] shifted;
  logic [word_width-1:0] size_mask;

  // ids go out in rotation, tail entry still busy means all four in use
  assign alloc_id_o    = tail_r;
  assign alloc_ready_o = ~busy_r[tail_r];

  //////////////////////////////////////////////////////////////////////
  // pointers and flags
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      busy_r   <= '0;
      filled_r <= '0;
      head_r   <= '0;
      tail_r   <= '0;
    end
    else
    begin
      if (alloc_v_i)
      begin
        busy_r[tail_r] <= 1'b1;
        tail_r         <= tail_r + 1'b1;
      end
      // returns land in any order
      if (ret_v_i)
        filled_r[ret_reg_id_i] <= 1'b1;
      if (drain)
      begin
        busy_r[head_r]   <= 1'b0;
        filled_r[head_r] <= 1'b0;
        head_r           <= head_r + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (alloc_v_i)
    begin
      tag_r[tail_r]  <= cmd_tag_i;
      we_r[tail_r]   <= cmd_we_i;
      size_r[tail_r] <= cmd_size_i;
      lane_r[tail_r] <= lane_i;
    end
    if (ret_v_i)
      data_r[ret_reg_id_i] <= ret_data_i;
  end

  //////////////////////////////////////////////////////////////////////
  // in-order response
  //////////////////////////////////////////////////////////////////////

  // only the oldest entry may answer
  assign resp_v_o   = filled_r[head_r];
  assign drain      = resp_v_o & resp_ready_i;
  assign resp_tag_o = tag_r[head_r];
  assign resp_we_o  = we_r[head_r];

  // bring the addressed bytes down to bit 0
  assign shifted = data_r[head_r] >> {lane_r[head_r], 3'b000};

  always_comb
  begin
    case (size_r[head_r])
      size_1:
        size_mask = word_width'(8'hff);
      size_2:
        size_mask = word_width'(16'hffff);
      size_4:
        size_mask = '1;
      default:
        size_mask = '1;
    endcase
  end

  // store acks carry no data
  assign resp_data_o = we_r[head_r] ? '0 : (shifted & size_mask);

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
  --top-module tb_mc_bridge \
  -f flist.f \
  -o sim_mc_bridge

./obj_dir/sim_mc_bridge > sim.log 2>&1 || true
cat sim.log

if grep -qx "STATUS: PASS" sim.log; then
  exit 0
fi
exit 1

// ==== test/tb_mc_bridge.sv ====
module tb_mc_bridge;

  import bridge_cmd_pkg::*;
  import mc_net_pkg::*;

  localparam int clk_period      = 10;
  localparam int reset_cycles    = 10;
  localparam int num_tests       = 5;
  localparam int cycles_per_test = 400;

  logic                      clk_i;
  logic                      arst_n_i;
  cord_t                     my_x_i;
  cord_t                     my_y_i;
  logic                      cmd_valid_i;
  logic                      cmd_ready_o;
  logic [cmd_addr_width-1:0] cmd_addr_i;
  logic                      cmd_we_i;
  size_t                     cmd_size_i;
  logic [word_width-1:0]     cmd_data_i;
  logic [tag_width-1:0]      cmd_tag_i;
  logic                      pkt_v_o;
  logic                      pkt_ready_i;
  op_e                       pkt_op_o;
  mc_addr_t                  pkt_addr_o;
  logic [mask_width-1:0]     pkt_mask_o;
  payload_u                  pkt_payload_o;
  trans_id_t                 pkt_reg_id_o;
  cord_t                     pkt_x_o;
  cord_t                     pkt_y_o;
  cord_t                     pkt_src_x_o;
  cord_t                     pkt_src_y_o;
  logic                      ret_v_i;
  trans_id_t                 ret_reg_id_i;
  logic [word_width-1:0]     ret_data_i;
  logic                      resp_v_o;
  logic                      resp_ready_i;
  logic [tag_width-1:0]      resp_tag_o;
  logic                      resp_we_o;
  logic [word_width-1:0]     resp_data_o;

  integer    seed;
  int        checks;
  int        errors;
  trans_id_t next_id;

  // expected packet of the command in flight
  op_e                   exp_op;
  mc_addr_t              exp_addr;
  cord_t                 exp_x;
  cord_t                 exp_y;
  logic [mask_width-1:0] exp_mask;
  payload_u              exp_payload;
  trans_id_t             exp_id;

  // network model words keyed by {x, y, word address}
  logic [word_width-1:0] mem [logic [39:0]];
  trans_id_t             pend_id [$];
  logic [word_width-1:0] pend_data [$];

  mc_bridge_top DUT (.*);

  always #(clk_period / 2) clk_i = ~clk_i;

  //////////////////////////////////////////////////////////////////////
  // reference rules
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] local_addr(input cord_t y, input cord_t x,
                                             input logic [15:0] widx, input logic [1:0] lane);
    return {2'b00, y, x, widx, lane};
  endfunction

  function automatic logic [39:0] mem_key(input cord_t x, input cord_t y, input mc_addr_t a);
    return {x, y, a};
  endfunction

  // untouched words read back a pattern of their own key
  function automatic logic [31:0] read_word(input logic [39:0] key);
    if (mem.exists(key))
      return mem[key];
    return key[31:0] ^ {4{key[39:32]}} ^ 32'h9e3779b9;
  endfunction

  function automatic int size_bytes(input size_t size);
    return (size == size_1) ? 1 : (size == size_2) ? 2 : 4;
  endfunction

  function automatic logic [31:0] trim_load(input logic [31:0] word, input size_t size,
                                            input logic [1:0] lane);
    logic [31:0] shifted;
    shifted = word >> (8 * lane);
    if (size_bytes(size) < 4)
      shifted = shifted & ((32'd1 << (8 * size_bytes(size))) - 32'd1);
    return shifted;
  endfunction

  task automatic set_expected(input logic [31:0] addr, input logic we, input size_t size,
                              input logic [31:0] data);
    logic [28:0] w;
    logic [2:0]  bank;
    logic [7:0]  wide_mask;
    w = addr[30:2];
    bank = 3'(w % 8);
    if (!addr[31])
    begin
      exp_y    = addr[29:24];
      exp_x    = addr[23:18];
      exp_addr = mc_addr_t'(addr[17:2]);
    end
    else
    begin
      // DRAM banks sit on row 0 and on the row below the array
      exp_x    = cord_t'(bank % 4);
      exp_y    = (bank >= 4) ? cord_t'(num_tiles_y + 1) : cord_t'(0);
      exp_addr = mc_addr_t'(w / 8);
    end
    wide_mask   = ((8'd1 << size_bytes(size)) - 8'd1) << addr[1:0];
    exp_mask    = wide_mask[3:0];
    exp_op      = we ? e_store : e_load;
    exp_payload = '0;
    if (we)
      exp_payload.store_data = data << (8 * addr[1:0]);
    else
    begin
      exp_payload.load.info.is_byte  = (size_bytes(size) == 1);
      exp_payload.load.info.is_half  = (size_bytes(size) == 2);
      exp_payload.load.info.part_sel = addr[1:0];
    end
    exp_id  = next_id;
    next_id = next_id + 2'd1;
  endtask

  //////////////////////////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic compare_field(input string name, input string field, input logic [31:0] exp,
                               input logic [31:0] act);
    checks++;
    if (exp !== act)
    begin
      errors++;
      $display("Error: %s %s expected %h actual %h", name, field, exp, act);
    end
  endtask

  task automatic check_packet(input string name, input op_e op, input mc_addr_t addr,
                              input cord_t x, input cord_t y, input cord_t src_x,
                              input cord_t src_y, input logic [mask_width-1:0] mask,
                              input payload_u payload, input trans_id_t id);
    compare_field(name, "op", 32'(exp_op), 32'(op));
    compare_field(name, "addr", 32'(exp_addr), 32'(addr));
    compare_field(name, "x", 32'(exp_x), 32'(x));
    compare_field(name, "y", 32'(exp_y), 32'(y));
    compare_field(name, "src", {my_y_i, my_x_i}, {src_y, src_x});
    compare_field(name, "mask", 32'(exp_mask), 32'(mask));
    compare_field(name, "payload", exp_payload, payload);
    compare_field(name, "reg id", 32'(exp_id), 32'(id));
  endtask

  task automatic check_resp(input string name, input logic [tag_width-1:0] exp_tag,
                            input logic exp_we, input logic [word_width-1:0] exp_data,
                            input logic [tag_width-1:0] tag, input logic we,
                            input logic [word_width-1:0] data);
    compare_field(name, "resp tag", 32'(exp_tag), 32'(tag));
    compare_field(name, "resp we", 32'(exp_we), 32'(we));
    compare_field(name, "resp data", exp_data, data);
  endtask

  //////////////////////////////////////////////////////////////////////
  // network model and bus tasks
  //////////////////////////////////////////////////////////////////////

  // a packet seen at the falling edge moves on the next rising edge
  always @(negedge clk_i)
  begin : net_model
    logic [39:0] key;
    logic [31:0] word;
    if (arst_n_i && pkt_v_o && pkt_ready_i)
    begin
      key  = mem_key(pkt_x_o, pkt_y_o, pkt_addr_o);
      word = read_word(key);
      if (pkt_op_o == e_store)
      begin
        for (int b = 0; b < mask_width; b++)
          if (pkt_mask_o[b])
            word[8*b+:8] = pkt_payload_o.store_data[8*b+:8];
        mem[key] = word;
        word     = '0;
      end
      pend_id.push_back(pkt_reg_id_o);
      pend_data.push_back(word);
    end
  end

  task automatic issue_cmd(input logic [31:0] addr, input logic we, input size_t size,
                           input logic [31:0] data, input logic [tag_width-1:0] tag);
    @(posedge clk_i);
    #1;
    cmd_valid_i = 1'b1;
    cmd_addr_i  = addr;
    cmd_we_i    = we;
    cmd_size_i  = size;
    cmd_data_i  = data;
    cmd_tag_i   = tag;
    @(negedge clk_i);
    while (!cmd_ready_o)
      @(negedge clk_i);
    @(posedge clk_i);
    #1;
    cmd_valid_i = 1'b0;
  endtask

  task automatic expect_packet(input string name);
    @(negedge clk_i);
    while (!pkt_v_o)
      @(negedge clk_i);
    check_packet(name, pkt_op_o, pkt_addr_o, pkt_x_o, pkt_y_o, pkt_src_x_o, pkt_src_y_o,
                 pkt_mask_o, pkt_payload_o, pkt_reg_id_o);
  endtask

  task automatic send_return(input logic newest);
    trans_id_t   id;
    logic [31:0] data;
    while (pend_id.size() == 0)
      @(negedge clk_i);
    id   = newest ? pend_id.pop_back() : pend_id.pop_front();
    data = newest ? pend_data.pop_back() : pend_data.pop_front();
    @(posedge clk_i);
    #1;
    ret_v_i      = 1'b1;
    ret_reg_id_i = id;
    ret_data_i   = data;
    @(posedge clk_i);
    #1;
    ret_v_i = 1'b0;
  endtask

  task automatic take_resp(input string name, input logic [tag_width-1:0] tag,
                           input logic we, input logic [31:0] data);
    @(posedge clk_i);
    #1;
    resp_ready_i = 1'b1;
    @(negedge clk_i);
    while (!resp_v_o)
      @(negedge clk_i);
    check_resp(name, tag, we, data, resp_tag_o, resp_we_o, resp_data_o);
    @(posedge clk_i);
    #1;
    resp_ready_i = 1'b0;
  endtask

  // one command end to end with the network answering at once
  task automatic run_cmd(input string name, input logic [31:0] addr, input logic we,
                         input size_t size, input logic [31:0] data,
                         input logic [tag_width-1:0] tag);
    logic [31:0] exp_data;
    set_expected(addr, we, size, data);
    exp_data = we ? '0 : trim_load(read_word(mem_key(exp_x, exp_y, exp_addr)), size, addr[1:0]);
    issue_cmd(addr, we, size, data, tag);
    expect_packet(name);
    send_return(1'b0);
    take_resp(name, tag, we, exp_data);
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic store_then_load_local;
    logic [31:0] addr;
    logic [31:0] data;
    addr = local_addr(6'd2, 6'd3, 16'h0123, 2'd0);
    data = $random(seed);
    run_cmd("local_store", addr, 1'b1, size_4, data, 4'h1);
    set_expected(addr, 1'b0, size_4, '0);
    issue_cmd(addr, 1'b0, size_4, '0, 4'h2);
    expect_packet("local_load");
    send_return(1'b0);
    take_resp("local_load", 4'h2, 1'b0, data);
  endtask

  task automatic sweep_remote_banks;
    logic [28:0] w;
    for (int b = 0; b < num_banks; b++)
    begin
      w = {26'($random(seed)), 3'(b)};
      run_cmd($sformatf("remote_bank%0d", b), {1'b1, w, 2'b00}, 1'b0, size_4, '0, 4'(b));
    end
  endtask

  task automatic sweep_lanes;
    logic [31:0] addr;
    size_t       size;
    for (int s = 0; s < 2; s++)
    begin
      for (int lane = 0; lane < 4; lane++)
      begin
        size = (s == 0) ? size_1 : size_2;
        addr = local_addr(6'd1, 6'd1, 16'h0200 + 16'(s), 2'(lane));
        run_cmd($sformatf("lane_store s%0d l%0d", s, lane), addr, 1'b1, size,
                $random(seed), 4'(lane));
        run_cmd($sformatf("lane_load s%0d l%0d", s, lane), addr, 1'b0, size, '0, 4'(lane + 4));
      end
    end
  endtask

  task automatic reorder_returns;
    logic [31:0] addr;
    logic [31:0] words [4];
    for (int i = 0; i < 4; i++)
    begin
      addr = local_addr(6'd3, 6'd0, 16'h0300 + 16'(i), 2'd0);
      set_expected(addr, 1'b0, size_4, '0);
      words[i] = read_word(mem_key(exp_x, exp_y, exp_addr));
      issue_cmd(addr, 1'b0, size_4, '0, 4'(8 + i));
      expect_packet("reorder");
    end
    compare_field("reorder", "cmd_ready_o with four outstanding", 0, cmd_ready_o);
    while (pend_id.size() < 4)
      @(negedge clk_i);
    for (int i = 0; i < 3; i++)
      send_return(1'b1);
    // nothing may answer while the oldest id is missing
    @(negedge clk_i);
    compare_field("reorder", "resp_v_o before the oldest return", 0, resp_v_o);
    send_return(1'b1);
    for (int i = 0; i < 4; i++)
      take_resp("reorder", 4'(8 + i), 1'b0, words[i]);
  endtask

  task automatic hold_under_backpressure;
    logic [31:0] addr;
    logic [31:0] word;
    @(posedge clk_i);
    #1;
    pkt_ready_i = 1'b0;
    addr = local_addr(6'd0, 6'd2, 16'h0040, 2'd0);
    set_expected(addr, 1'b0, size_4, '0);
    word = read_word(mem_key(exp_x, exp_y, exp_addr));
    issue_cmd(addr, 1'b0, size_4, '0, 4'hc);
    // new command fields must not leak into the held packet
    cmd_addr_i = ~addr;
    cmd_we_i   = 1'b1;
    repeat (6)
    begin
      @(negedge clk_i);
      compare_field("pkt_hold", "pkt_v_o", 1, pkt_v_o);
      compare_field("pkt_hold", "cmd_ready_o", 0, cmd_ready_o);
      check_packet("pkt_hold", pkt_op_o, pkt_addr_o, pkt_x_o, pkt_y_o, pkt_src_x_o,
                   pkt_src_y_o, pkt_mask_o, pkt_payload_o, pkt_reg_id_o);
    end
    @(posedge clk_i);
    #1;
    pkt_ready_i = 1'b1;
    send_return(1'b0);
    @(negedge clk_i);
    while (!resp_v_o)
      @(negedge clk_i);
    repeat (5)
    begin
      compare_field("resp_hold", "resp_v_o", 1, resp_v_o);
      check_resp("resp_hold", 4'hc, 1'b0, word, resp_tag_o, resp_we_o, resp_data_o);
      @(negedge clk_i);
    end
    take_resp("resp_hold", 4'hc, 1'b0, word);
    // ids keep rotating through the wrap
    for (int i = 0; i < 5; i++)
      run_cmd("id_wrap", local_addr(6'd0, 6'd3, 16'h0400 + 16'(i), 2'd0), 1'b0, size_4,
              '0, 4'(i));
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    #((reset_cycles + num_tests * cycles_per_test) * clk_period);
    $display("watchdog expired at %0t, the DUT stopped answering", $time);
    $display("checks %0d errors %0d", checks, errors);
    $display("STATUS: FAIL");
    $finish;
  end

  initial
  begin
    clk_i        = 1'b0;
    arst_n_i     = 1'b0;
    my_x_i       = 6'd1;
    my_y_i       = 6'd2;
    cmd_valid_i  = 1'b0;
    cmd_addr_i   = '0;
    cmd_we_i     = 1'b0;
    cmd_size_i   = size_4;
    cmd_data_i   = '0;
    cmd_tag_i    = '0;
    pkt_ready_i  = 1'b1;
    ret_v_i      = 1'b0;
    ret_reg_id_i = '0;
    ret_data_i   = '0;
    resp_ready_i = 1'b0;
    seed         = 32'h1404a83d;
    checks       = 0;
    errors       = 0;
    next_id      = '0;
    repeat (reset_cycles) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;
    @(negedge clk_i);
    compare_field("reset", "cmd_ready_o", 1, cmd_ready_o);
    compare_field("reset", "pkt_v_o", 0, pkt_v_o);
    compare_field("reset", "resp_v_o", 0, resp_v_o);
    store_then_load_local;
    sweep_remote_banks;
    sweep_lanes;
    reorder_returns;
    hold_under_backpressure;
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule
